/* rv_cpu.f */
rv_pkg.sv
rv_decode.sv
rv_alu.sv
rv_regfile.sv
rv_lsu.sv
rv_ctrl.sv
rv_cpu.sv
tb_wb_mem.sv
tb_rv_cpu.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  := rv_cpu.f
TB_TOP    := tb_rv_cpu
RTL_TOP   := rv_cpu
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tb_rv_cpu.sv */
// Testbench for the RV32I core that runs a hand-assembled program
// and checks every store it makes against an expected table
`timescale 1ns/1ps
`default_nettype none

module tb_rv_cpu;

   localparam logic [31:0] start_pc = 32'h0000_0040;
   localparam logic [31:0] sp_vec = 32'h0000_03f0;
   localparam logic [31:0] data_word = 32'h8a7b_c6f5;
   localparam logic [11:0] data_adr = 12'h2f0;
   localparam logic [11:0] bad_adr = 12'h3fc;

   logic clk = 1'b0;
   logic rst_n;
   logic cyc;
   logic stb;
   logic we;
   logic ack;
   logic fault;
   logic [15:0] adr;
   logic [31:0] dat_w;
   logic [31:0] dat_r;
   logic [3:0] sel;
   logic log_valid;
   logic [15:0] log_adr;
   logic [31:0] log_dat;
   logic [3:0] log_sel;

   logic [31:0] prog [200];
   int n_prog;
   logic [11:0] res_ptr;
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];
   logic [3:0] exp_sel [$];
   int n_reads;
   logic [15:0] first_fetch;

   // Load table of funct3, byte offset and expected register value
   // Sizes that do not fit at their offset read as zero
   logic [2:0] ld_f3 [20] = '{3'b000, 3'b000, 3'b000, 3'b000, 3'b100, 3'b100, 3'b100,
      3'b100, 3'b001, 3'b001, 3'b001, 3'b001, 3'b101, 3'b101, 3'b101, 3'b101,
      3'b010, 3'b010, 3'b010, 3'b010};
   logic [1:0] ld_off [20] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3};
   logic [31:0] ld_exp [20] = '{32'hffff_fff5, 32'hffff_ffc6, 32'h0000_007b,
      32'hffff_ff8a, 32'h0000_00f5, 32'h0000_00c6, 32'h0000_007b, 32'h0000_008a,
      32'hffff_c6f5, 32'h0000_7bc6, 32'hffff_8a7b, 32'h0000_0000, 32'h0000_c6f5,
      32'h0000_7bc6, 32'h0000_8a7b, 32'h0000_0000, 32'h8a7b_c6f5, 32'h0000_0000,
      32'h0000_0000, 32'h0000_0000};

   // Branch funct3 and operand registers for the taken and the not-taken case
   // x5 holds -8, x6 holds 3, x7 holds 100
   logic [2:0] br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
   logic [4:0] br_t1 [6] = '{6, 6, 5, 6, 6, 5};
   logic [4:0] br_t2 [6] = '{6, 7, 6, 5, 5, 6};
   logic [4:0] br_n1 [6] = '{6, 6, 6, 5, 5, 6};
   logic [4:0] br_n2 [6] = '{7, 6, 5, 6, 6, 5};

   always #4 clk = ~clk;

   rv_cpu i_dut (
      .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack), .fault(fault)
   );

   tb_wb_mem #(.rng_seed(32'hb7069f4e)) i_mem (
      .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack), .log_valid(log_valid),
      .log_adr(log_adr), .log_dat(log_dat), .log_sel(log_sel)
   );

   // Third acknowledged read is the first instruction fetch
   always @(negedge clk) begin
      if (!rst_n) begin
         n_reads <= 0;
         first_fetch <= '0;
      end else if (cyc && ack && !we) begin
         if (n_reads == 2) first_fetch <= adr;
         n_reads <= n_reads + 1;
      end
   end

   function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
      return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] pc_now();
      return start_pc + 32'(4 * n_prog);
   endfunction

   task automatic emit(input logic [31:0] word);
      prog[n_prog] = word;
      n_prog++;
   endtask

   task automatic expect_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
      exp_adr.push_back(a);
      exp_dat.push_back(d);
      exp_sel.push_back(s);
   endtask

   // sw of a result register to the next free result word
   task automatic store_result(input logic [4:0] rs2, input logic [31:0] value);
      emit(enc_s(res_ptr, rs2, 3'b010));
      expect_store({20'd0, res_ptr}, value, 4'hf);
      res_ptr = res_ptr + 12'd4;
   endtask

   task automatic build_program();
      logic [31:0] p;
      logic [11:0] a;
      n_prog = 0;
      res_ptr = 12'h300;
      store_result(5'd2, sp_vec);
      emit(enc_i(12'hff8, 5'd0, 3'b000, 5'd5, 7'b0010011));
      emit(enc_i(12'd3, 5'd0, 3'b000, 5'd6, 7'b0010011));
      emit(enc_i(12'd100, 5'd0, 3'b000, 5'd7, 7'b0010011));
      emit(enc_r(7'h00, 3'b000, 5'd8, 5'd7, 5'd6));
      store_result(5'd8, 32'h0000_0067);
      emit(enc_r(7'h20, 3'b000, 5'd8, 5'd6, 5'd7));
      store_result(5'd8, 32'hffff_ff9f);
      emit(enc_r(7'h00, 3'b001, 5'd8, 5'd7, 5'd6));
      store_result(5'd8, 32'h0000_0320);
      emit(enc_r(7'h00, 3'b101, 5'd8, 5'd5, 5'd6));
      store_result(5'd8, 32'h1fff_ffff);
      emit(enc_r(7'h20, 3'b101, 5'd8, 5'd5, 5'd6));
      store_result(5'd8, 32'hffff_ffff);
      emit(enc_r(7'h00, 3'b010, 5'd8, 5'd5, 5'd6));
      store_result(5'd8, 32'h0000_0001);
      emit(enc_r(7'h00, 3'b011, 5'd8, 5'd5, 5'd6));
      store_result(5'd8, 32'h0000_0000);
      emit(enc_r(7'h00, 3'b100, 5'd8, 5'd7, 5'd5));
      store_result(5'd8, 32'hffff_ff9c);
      emit(enc_r(7'h00, 3'b110, 5'd8, 5'd7, 5'd6));
      store_result(5'd8, 32'h0000_0067);
      emit(enc_r(7'h00, 3'b111, 5'd8, 5'd7, 5'd5));
      store_result(5'd8, 32'h0000_0060);
      emit(enc_i(12'hfff, 5'd7, 3'b000, 5'd8, 7'b0010011));
      store_result(5'd8, 32'h63);
      emit(enc_i(12'hff9, 5'd5, 3'b010, 5'd8, 7'b0010011));
      store_result(5'd8, 32'h1);
      emit(enc_i(12'hfff, 5'd6, 3'b011, 5'd8, 7'b0010011));
      store_result(5'd8, 32'h1);
      emit(enc_i(12'h00f, 5'd7, 3'b100, 5'd8, 7'b0010011));
      store_result(5'd8, 32'h6b);
      emit(enc_i(12'h103, 5'd7, 3'b110, 5'd8, 7'b0010011));
      store_result(5'd8, 32'h167);
      emit(enc_i(12'h7f0, 5'd5, 3'b111, 5'd8, 7'b0010011));
      store_result(5'd8, 32'h7f0);
      emit(enc_i(12'h004, 5'd6, 3'b001, 5'd8, 7'b0010011));
      store_result(5'd8, 32'h30);
      emit(enc_i(12'h01c, 5'd5, 3'b101, 5'd8, 7'b0010011));
      store_result(5'd8, 32'hf);
      emit(enc_i(12'h401, 5'd5, 3'b101, 5'd8, 7'b0010011));
      store_result(5'd8, 32'hffff_fffc);
      emit({20'h12345, 5'd8, 7'b0110111});
      store_result(5'd8, 32'h1234_5000);
      p = pc_now();
      emit({20'h00001, 5'd8, 7'b0010111});
      store_result(5'd8, p + 32'h1000);
      // Write to x0 is dropped
      emit(enc_i(12'd5, 5'd7, 3'b000, 5'd0, 7'b0010011));
      store_result(5'd0, 32'h0);
      for (int k = 0; k < 20; k++) begin
         emit(enc_i(data_adr + 12'(ld_off[k]), 5'd0, ld_f3[k], 5'd8, 7'b0000011));
         store_result(5'd8, ld_exp[k]);
      end
      emit({20'h11223, 5'd9, 7'b0110111});
      emit(enc_i(12'h344, 5'd9, 3'b000, 5'd9, 7'b0010011));
      for (int k = 0; k < 4; k++) begin
         a = 12'h3d0 + 12'(4 * k + k);
         emit(enc_s(a, 5'd9, 3'b000));
         expect_store({20'd0, a}, 32'h1122_3344 << (8 * k), 4'b0001 << k);
      end
      for (int k = 0; k < 3; k++) begin
         a = 12'h3e0 + 12'(4 * k + k);
         emit(enc_s(a, 5'd9, 3'b001));
         expect_store({20'd0, a}, 32'h1122_3344 << (8 * k), 4'b0011 << k);
      end
      emit(enc_s(12'h3ec, 5'd9, 3'b010));
      expect_store(32'h3ec, 32'h1122_3344, 4'hf);
      // Taken branch skips a store that is not expected
      for (int k = 0; k < 6; k++) begin
         emit(enc_b(13'd8, br_t1[k], br_t2[k], br_f3[k]));
         emit(enc_s(bad_adr, 5'd0, 3'b010));
         emit(enc_b(13'd8, br_n1[k], br_n2[k], br_f3[k]));
         store_result(5'd7, 32'd100);
      end
      p = pc_now();
      emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd8, 7'b1101111});
      emit(enc_s(bad_adr, 5'd0, 3'b010));
      store_result(5'd8, p + 32'd4);
      p = pc_now();
      emit(enc_i(12'(p + 32'd12), 5'd0, 3'b000, 5'd10, 7'b0010011));
      emit(enc_i(12'd0, 5'd10, 3'b000, 5'd8, 7'b1100111));
      emit(enc_s(bad_adr, 5'd0, 3'b010));
      store_result(5'd8, p + 32'd8);
      // Undefined opcode
      emit(32'h0000_0000);
   endtask

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Test FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic timed_out(input string what);
      $display("Timed out waiting for %s at %0t ns", what, $time);
      $display("Test FAILED");
      $fatal(1, "timeout");
   endtask

   task automatic wait_store();
      for (int i = 0; i < 2000; i++) begin
         @(negedge clk);
         if (log_valid) return;
      end
      timed_out("a store");
   endtask

   task automatic wait_fault();
      for (int i = 0; i < 2000; i++) begin
         @(negedge clk);
         check("unexpected store", {31'd0, log_valid}, 32'd0);
         if (fault) return;
      end
      timed_out("the fault output");
   endtask

   initial begin
      rst_n = 1'b0;
      build_program();
      for (int i = 0; i < 256; i++) begin
         i_mem.mem[i] = 32'hc300_0000 | (32'(i) << 2);
      end
      i_mem.mem[0] = start_pc;
      i_mem.mem[1] = sp_vec;
      i_mem.mem[data_adr[9:2]] = data_word;
      for (int i = 0; i < n_prog; i++) begin
         i_mem.mem[start_pc[9:2] + 8'(i)] = prog[i];
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      for (int k = 0; k < exp_adr.size(); k++) begin
         wait_store();
         check("store address", {16'd0, log_adr}, exp_adr[k]);
         check("store data", log_dat, exp_dat[k]);
         check("store select", {28'd0, log_sel}, {28'd0, exp_sel[k]});
         if (k == 0) check("first fetch address", {16'd0, first_fetch}, start_pc);
      end
      wait_fault();
      repeat (50) begin
         @(negedge clk);
         check("cyc after fault", {31'd0, cyc}, 32'd0);
         check("fault", {31'd0, fault}, 32'd1);
      end
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

/* tb_wb_mem.sv */
// Behavioral Wishbone classic memory, 1 KB, random ack delay
// Reports every acknowledged write on the log outputs
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem #(
   parameter int unsigned rng_seed = 32'hb7069f4e
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [15:0] adr,
   input  logic [31:0] dat_w,
   input  logic [3:0]  sel,
   output logic [31:0] dat_r,
   output logic        ack,
   output logic        log_valid,
   output logic [15:0] log_adr,
   output logic [31:0] log_dat,
   output logic [3:0]  log_sel
);

   logic [31:0] mem [256];
   logic [1:0] wait_cnt;
   logic armed;
   bit seeded;

   always @(posedge clk) begin
      // One seed for the whole run
      if (!seeded) begin
         void'($urandom(rng_seed));
         seeded = 1'b1;
      end
      log_valid <= 1'b0;
      if (!rst_n) begin
         ack <= 1'b0;
         armed <= 1'b0;
         dat_r <= '0;
      end else if (ack) begin
         ack <= 1'b0;
         armed <= 1'b0;
      end else if (cyc && stb) begin
         if (!armed) begin
            armed <= 1'b1;
            wait_cnt <= 2'($urandom % 4);
         end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end else begin
            ack <= 1'b1;
            dat_r <= mem[adr[9:2]];
            if (we) begin
               for (int b = 0; b < 4; b++) begin
                  if (sel[b]) begin
                     mem[adr[9:2]][8*b +: 8] = dat_w[8*b +: 8];
                  end
               end
               log_valid <= 1'b1;
               log_adr <= adr;
               log_dat <= dat_w;
               log_sel <= sel;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rv_cpu.sv */
// RV32I multi-cycle core top with a Wishbone classic master port
`timescale 1ns/1ps
`default_nettype none

module rv_cpu import rv_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   output logic              cyc,
   output logic              stb,
   output logic              we,
   output logic [addr_w-1:0] adr,
   output logic [xlen-1:0]   dat_w,
   output logic [3:0]        sel,
   input  logic [xlen-1:0]   dat_r,
   input  logic              ack,
   output logic              fault
);

   logic [xlen-1:0] inst;
   logic [xlen-1:0] imm;
   logic [6:0] opcode;
   logic [6:0] funct7;
   logic [4:0] rd;
   logic [4:0] rs1;
   logic [4:0] rs2;
   logic [2:0] funct3;
   logic ren;
   logic wen;
   logic [xlen-1:0] wdata;
   logic [xlen-1:0] rs1_val;
   logic [xlen-1:0] rs2_val;
   logic [xlen-1:0] alu_x;
   logic [xlen-1:0] alu_y;
   logic [xlen-1:0] alu_y_out;
   logic [3:0] alu_fn;
   logic alu_zero;
   logic [xlen-1:0] st_data;
   logic [xlen-1:0] ld_val;
   logic [3:0] st_sel;

   rv_ctrl i_ctrl (
      .clk(clk), .rst_n(rst_n),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
      .dat_r(dat_r), .ack(ack), .fault(fault), .inst(inst),
      .opcode(opcode), .funct3(funct3), .funct7(funct7), .imm(imm),
      .ren(ren), .wen(wen), .wdata(wdata), .rs1_val(rs1_val), .rs2_val(rs2_val),
      .alu_x(alu_x), .alu_y(alu_y), .alu_fn(alu_fn),
      .alu_y_out(alu_y_out), .alu_zero(alu_zero),
      .st_data(st_data), .st_sel(st_sel), .ld_val(ld_val)
   );

   rv_decode i_decode (
      .inst(inst), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2),
      .funct3(funct3), .funct7(funct7), .imm(imm)
   );

   rv_alu i_alu (
      .x(alu_x), .y(alu_y), .fn(alu_fn), .y_out(alu_y_out), .zero(alu_zero)
   );

   rv_regfile i_regfile (
      .clk(clk), .ren(ren), .rs1(rs1), .rs2(rs2),
      .wen(wen), .rd(rd), .wdata(wdata), .rs1_val(rs1_val), .rs2_val(rs2_val)
   );

   rv_lsu i_lsu (
      .funct3(funct3), .addr_lo(alu_y_out[1:0]), .rs2_val(rs2_val), .dat_r(dat_r),
      .st_data(st_data), .st_sel(st_sel), .ld_val(ld_val)
   );

endmodule

`default_nettype wire

/* rv_ctrl.sv */
// Multi-cycle control FSM with PC, branch decision and Wishbone master
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl import rv_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   output logic              cyc,
   output logic              stb,
   output logic              we,
   output logic [addr_w-1:0] adr,
   output logic [xlen-1:0]   dat_w,
   output logic [3:0]        sel,
   input  logic [xlen-1:0]   dat_r,
   input  logic              ack,
   output logic              fault,
   output logic [xlen-1:0]   inst,
   input  logic [6:0]        opcode,
   input  logic [2:0]        funct3,
   input  logic [6:0]        funct7,
   input  logic [xlen-1:0]   imm,
   output logic              ren,
   output logic              wen,
   output logic [xlen-1:0]   wdata,
   input  logic [xlen-1:0]   rs1_val,
   input  logic [xlen-1:0]   rs2_val,
   output logic [xlen-1:0]   alu_x,
   output logic [xlen-1:0]   alu_y,
   output logic [3:0]        alu_fn,
   input  logic [xlen-1:0]   alu_y_out,
   input  logic              alu_zero,
   input  logic [xlen-1:0]   st_data,
   input  logic [3:0]        st_sel,
   input  logic [xlen-1:0]   ld_val
);

   state_t state;
   alu_x_sel_t x_sel;
   alu_y_sel_t y_sel;
   logic [addr_w-1:0] pc;
   logic [addr_w-1:0] pc_plus_4;
   logic [addr_w-1:0] pc_plus_imm;
   logic [addr_w-1:0] req_adr;
   logic req;
   logic done;
   logic branch;
   logic valid_op;

   assign done = cyc & ack;
   assign fault = (state == st_fault);
   assign pc_plus_4 = pc + addr_w'(4);
   assign pc_plus_imm = pc + imm[addr_w-1:0];

   // ALU function and operands
   always_comb begin
      alu_fn = alu_fn_add;
      x_sel = alu_x_rs1;
      y_sel = alu_y_imm;
      case (opcode)
         op_alu_r: begin
            alu_fn = {funct7[5], funct3};
            y_sel = alu_y_rs2;
         end
         op_alu_i: begin
            alu_fn = {(funct3 == 3'b001 || funct3 == 3'b101) & funct7[5], funct3};
         end
         op_branch: begin
            case (funct3)
               br_blt, br_bge:   alu_fn = alu_fn_lt;
               br_bltu, br_bgeu: alu_fn = alu_fn_ltu;
               default:          alu_fn = alu_fn_sub;
            endcase
            y_sel = alu_y_rs2;
         end
         // ALU makes the link value, the target comes from pc_plus_imm
         op_jal: begin
            x_sel = alu_x_pc;
            y_sel = alu_y_four;
         end
         op_auipc: x_sel = alu_x_pc;
         op_lui:   x_sel = alu_x_zero;
         default: ;
      endcase

      case (x_sel)
         alu_x_rs1: alu_x = rs1_val;
         alu_x_pc:  alu_x = {{(xlen-addr_w){1'b0}}, pc};
         default:   alu_x = '0;
      endcase

      case (y_sel)
         alu_y_rs2:  alu_y = rs2_val;
         alu_y_four: alu_y = xlen'(4);
         default:    alu_y = imm;
      endcase
   end

   always_comb begin
      case (funct3)
         br_beq:           branch = alu_zero;
         br_bne:           branch = !alu_zero;
         br_blt, br_bltu:  branch = alu_y_out[0];
         br_bge, br_bgeu:  branch = !alu_y_out[0];
         default:          branch = 1'b0;
      endcase
   end

   always_comb begin
      case (opcode)
         op_alu_r, op_alu_i, op_load, op_store, op_branch,
         op_jal, op_jalr, op_lui, op_auipc: valid_op = 1'b1;
         default: valid_op = 1'b0;
      endcase
   end

   // Register file strobes
   always_comb begin
      ren = (state == st_rd_reg);
      wen = 1'b0;
      wdata = alu_y_out;
      case (state)
         st_f_sp: begin
            wen = done;
            wdata = dat_r;
         end
         st_x_load: begin
            wen = done;
            wdata = ld_val;
         end
         st_x_jalr: begin
            wen = 1'b1;
            wdata = {{(xlen-addr_w){1'b0}}, pc_plus_4};
         end
         st_wb_reg, st_x_jal: wen = 1'b1;
         default: ;
      endcase
   end

   always_comb begin
      req = 1'b1;
      req_adr = pc;
      case (state)
         st_f_pc:               req_adr = vec_reset;
         st_f_sp:               req_adr = vec_sp;
         st_f_inst:             req_adr = pc;
         st_x_load, st_x_store: req_adr = alu_y_out[addr_w-1:0];
         default:               req = 1'b0;
      endcase
   end

   // Bus master; an idle cycle always follows each ack
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cyc <= 1'b0;
         stb <= 1'b0;
         we <= 1'b0;
         adr <= '0;
         dat_w <= '0;
         sel <= '0;
      end else if (cyc) begin
         if (ack) begin
            cyc <= 1'b0;
            stb <= 1'b0;
         end
      end else if (req) begin
         cyc <= 1'b1;
         stb <= 1'b1;
         we <= (state == st_x_store);
         adr <= req_adr;
         dat_w <= st_data;
         sel <= (state == st_x_store) ? st_sel : 4'b1111;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_f_pc;
         pc <= '0;
         inst <= inst_boot;
      end else begin
         case (state)
            st_f_pc: begin
               if (done) begin
                  pc <= dat_r[addr_w-1:0];
                  state <= st_f_sp;
               end
            end
            st_f_sp: if (done) state <= st_f_inst;
            st_f_inst: begin
               if (done) begin
                  inst <= dat_r;
                  state <= st_decode;
               end
            end
            st_decode: state <= valid_op ? st_rd_reg : st_fault;
            st_rd_reg: begin
               case (opcode)
                  op_load:   state <= st_x_load;
                  op_store:  state <= st_x_store;
                  op_branch: state <= st_x_branch;
                  op_jal:    state <= st_x_jal;
                  op_jalr:   state <= st_x_jalr;
                  default:   state <= st_wb_reg;
               endcase
            end
            st_wb_reg: begin
               pc <= pc_plus_4;
               state <= st_f_inst;
            end
            st_x_load, st_x_store: begin
               if (done) begin
                  pc <= pc_plus_4;
                  state <= st_f_inst;
               end
            end
            st_x_branch: begin
               pc <= branch ? pc_plus_imm : pc_plus_4;
               state <= st_f_inst;
            end
            st_x_jal: begin
               pc <= pc_plus_imm;
               state <= st_f_inst;
            end
            st_x_jalr: begin
               pc <= {alu_y_out[addr_w-1:1], 1'b0};
               state <= st_f_inst;
            end
            // Fault holds until reset
            default: state <= st_fault;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rv_lsu.sv */
// Load/store lane handling: store data and select, load extraction
`timescale 1ns/1ps
`default_nettype none

module rv_lsu import rv_pkg::*; (
   input  logic [2:0]      funct3,
   input  logic [1:0]      addr_lo,
   input  logic [xlen-1:0] rs2_val,
   input  logic [xlen-1:0] dat_r,
   output logic [xlen-1:0] st_data,
   output logic [3:0]      st_sel,
   output logic [xlen-1:0] ld_val
);

   assign st_data = rs2_val << {addr_lo, 3'b000};

   always_comb begin
      case ({funct3[1:0], addr_lo})
         4'b00_00: st_sel = 4'b0001;
         4'b00_01: st_sel = 4'b0010;
         4'b00_10: st_sel = 4'b0100;
         4'b00_11: st_sel = 4'b1000;
         4'b01_00: st_sel = 4'b0011;
         4'b01_01: st_sel = 4'b0110;
         4'b01_10: st_sel = 4'b1100;
         // Word, or a size that does not fit at this offset
         default:  st_sel = 4'b1111;
      endcase
   end

   always_comb begin
      case ({funct3, addr_lo})
         5'b000_00: ld_val = {{24{dat_r[7]}}, dat_r[7:0]};
         5'b000_01: ld_val = {{24{dat_r[15]}}, dat_r[15:8]};
         5'b000_10: ld_val = {{24{dat_r[23]}}, dat_r[23:16]};
         5'b000_11: ld_val = {{24{dat_r[31]}}, dat_r[31:24]};
         5'b001_00: ld_val = {{16{dat_r[15]}}, dat_r[15:0]};
         5'b001_01: ld_val = {{16{dat_r[23]}}, dat_r[23:8]};
         5'b001_10: ld_val = {{16{dat_r[31]}}, dat_r[31:16]};
         5'b010_00: ld_val = dat_r;
         5'b100_00: ld_val = {24'b0, dat_r[7:0]};
         5'b100_01: ld_val = {24'b0, dat_r[15:8]};
         5'b100_10: ld_val = {24'b0, dat_r[23:16]};
         5'b100_11: ld_val = {24'b0, dat_r[31:24]};
         5'b101_00: ld_val = {16'b0, dat_r[15:0]};
         5'b101_01: ld_val = {16'b0, dat_r[23:8]};
         5'b101_10: ld_val = {16'b0, dat_r[31:16]};
         default:   ld_val = '0;
      endcase
   end

endmodule

`default_nettype wire

/* rv_regfile.sv */
// 32 x 32 register file, registered dual read, x0 reads as zero
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
   input  logic            clk,
   input  logic            ren,
   input  logic [4:0]      rs1,
   input  logic [4:0]      rs2,
   input  logic            wen,
   input  logic [4:0]      rd,
   input  logic [xlen-1:0] wdata,
   output logic [xlen-1:0] rs1_val,
   output logic [xlen-1:0] rs2_val
);

   logic [xlen-1:0] regs [32];

   always_ff @(posedge clk) begin
      if (wen && rd != 5'd0) begin
         regs[rd] <= wdata;
      end
      if (ren) begin
         rs1_val <= (rs1 == 5'd0) ? '0 : regs[rs1];
         rs2_val <= (rs2 == 5'd0) ? '0 : regs[rs2];
      end
   end

endmodule

`default_nettype wire

/* rv_alu.sv */
// Combinational RV32I ALU with zero flag
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
   input  logic [xlen-1:0] x,
   input  logic [xlen-1:0] y,
   input  logic [3:0]      fn,
   output logic [xlen-1:0] y_out,
   output logic            zero
);

   always_comb begin
      case (fn)
         alu_fn_add: y_out = x + y;
         alu_fn_sub: y_out = x - y;
         alu_fn_sll: y_out = x << y[4:0];
         alu_fn_lt:  y_out = {{(xlen-1){1'b0}}, $signed(x) < $signed(y)};
         alu_fn_ltu: y_out = {{(xlen-1){1'b0}}, x < y};
         alu_fn_xor: y_out = x ^ y;
         alu_fn_srl: y_out = x >> y[4:0];
         alu_fn_sra: y_out = $unsigned($signed(x) >>> y[4:0]);
         alu_fn_or:  y_out = x | y;
         alu_fn_and: y_out = x & y;
         default:    y_out = '0;
      endcase
   end

   // BEQ and BNE look at this after a subtract
   assign zero = (y_out == '0);

endmodule

`default_nettype wire

/* rv_decode.sv */
// Instruction field splitter and immediate builder
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
   input  logic [xlen-1:0] inst,
   output logic [6:0]      opcode,
   output logic [4:0]      rd,
   output logic [4:0]      rs1,
   output logic [4:0]      rs2,
   output logic [2:0]      funct3,
   output logic [6:0]      funct7,
   output logic [xlen-1:0] imm
);

   assign opcode = inst[6:0];
   assign rd = inst[11:7];
   assign funct3 = inst[14:12];
   assign rs1 = inst[19:15];
   assign rs2 = inst[24:20];
   assign funct7 = inst[31:25];

   always_comb begin
      case (inst[6:0])
         op_alu_i,
         op_load,
         op_jalr: begin
            imm = {{20{inst[31]}}, inst[31:20]};
         end
         op_store: begin
            imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         end
         op_branch: begin
            imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
         end
         op_jal: begin
            imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         end
         op_lui,
         op_auipc: begin
            imm = {inst[31:12], 12'b0};
         end
         default: begin
            imm = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* rv_pkg.sv */
// Shared encodings for the multi-cycle RV32I core
// Opcodes, branch and ALU function codes, operand selects and FSM states
`default_nettype none

package rv_pkg;

   localparam int xlen = 32;
   localparam int addr_w = 16;

   localparam logic [addr_w-1:0] vec_reset = 16'h0000;
   localparam logic [addr_w-1:0] vec_sp = 16'h0004;

   // addi sp, zero, 0; its rd field steers the stack pointer load to x2
   localparam logic [xlen-1:0] inst_boot = 32'h0000_0113;

   localparam logic [6:0] op_alu_r = 7'b0110011;
   localparam logic [6:0] op_alu_i = 7'b0010011;
   localparam logic [6:0] op_load = 7'b0000011;
   localparam logic [6:0] op_store = 7'b0100011;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_jal = 7'b1101111;
   localparam logic [6:0] op_jalr = 7'b1100111;
   localparam logic [6:0] op_lui = 7'b0110111;
   localparam logic [6:0] op_auipc = 7'b0010111;

   localparam logic [2:0] br_beq = 3'b000;
   localparam logic [2:0] br_bne = 3'b001;
   localparam logic [2:0] br_blt = 3'b100;
   localparam logic [2:0] br_bge = 3'b101;
   localparam logic [2:0] br_bltu = 3'b110;
   localparam logic [2:0] br_bgeu = 3'b111;

   // {funct7[5], funct3}
   localparam logic [3:0] alu_fn_add = 4'b0000;
   localparam logic [3:0] alu_fn_sub = 4'b1000;
   localparam logic [3:0] alu_fn_sll = 4'b0001;
   localparam logic [3:0] alu_fn_lt = 4'b0010;
   localparam logic [3:0] alu_fn_ltu = 4'b0011;
   localparam logic [3:0] alu_fn_xor = 4'b0100;
   localparam logic [3:0] alu_fn_srl = 4'b0101;
   localparam logic [3:0] alu_fn_sra = 4'b1101;
   localparam logic [3:0] alu_fn_or = 4'b0110;
   localparam logic [3:0] alu_fn_and = 4'b0111;

   typedef enum logic [1:0] {alu_x_rs1, alu_x_pc, alu_x_zero} alu_x_sel_t;
   typedef enum logic [1:0] {alu_y_imm, alu_y_rs2, alu_y_four} alu_y_sel_t;

   typedef enum logic [4:0] {
      st_f_pc, st_f_sp, st_f_inst, st_decode, st_rd_reg, st_wb_reg,
      st_x_load, st_x_store, st_x_branch, st_x_jal, st_x_jalr, st_fault
   } state_t;

endpackage

`default_nettype wire
